//--- logic/lsu_stbuf.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_stbuf
   import stbuf_pkg::*;
#(
   parameter int DEPTH  = STBUF_DEPTH,
   parameter int ADDR_W = STBUF_ADDR_W
) (
   input  logic                 clk,
   input  logic                 rst_n,

   // store in dc3
   input  logic                 store_valid_dc3,
   input  access_size_e         store_size_dc3,
   input  logic [ADDR_W-1:0]    store_addr_dc3,
   input  logic [DATA_W-1:0]    store_data_dc3,

   input  logic                 lsu_commit_dc5,
   input  logic                 isldst_dc1,
   input  logic                 isldst_dc2,
   input  logic                 isldst_dc3,

   // memory side
   output logic                 stbuf_reqvld_any,
   output logic                 stbuf_reqvld_flushed_any,
   output logic [ADDR_W-1:0]    stbuf_addr_any,
   output logic [BYTE_W-1:0]    stbuf_byteen_any,
   output logic [DATA_W-1:0]    stbuf_data_any,
   input  logic                 lsu_stbuf_commit_any,

   output logic                 lsu_stbuf_full_any,
   output logic                 lsu_stbuf_empty_any,

   // load forwarding
   input  logic                 lsu_cmpen_dc2,
   input  logic [ADDR_W-1:0]    lsu_addr_dc2,
   input  access_size_e         load_size_dc2,
   output logic [DATA_W-1:0]    stbuf_fwddata_dc3,
   output logic [BYTE_W-1:0]    stbuf_fwdbyteen_dc3
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [ADDR_W-3:0]               wr_waddr;
   logic [BYTE_W-1:0]               wr_byteen;
   logic [DATA_W-1:0]               wr_data;

   entry_state_e [DEPTH-1:0]        entry_state;
   logic [DEPTH-1:0][ADDR_W-3:0]    entry_waddr;
   logic [DEPTH-1:0][BYTE_W-1:0]    entry_byteen;
   logic [DEPTH-1:0][DATA_W-1:0]    entry_data;
   logic [PTR_W-1:0]                wr_ptr;

   // ------------------------------
   // store lane decode
   // ------------------------------
   stbuf_write_decode #(
      .ADDR_W (ADDR_W)
   ) write_decode_i (
      .store_size_dc3 (store_size_dc3),
      .store_addr_dc3 (store_addr_dc3),
      .store_data_dc3 (store_data_dc3),
      .wr_waddr       (wr_waddr),
      .wr_byteen      (wr_byteen),
      .wr_data        (wr_data)
   );

   // entry array
   stbuf_entries #(
      .DEPTH  (DEPTH),
      .ADDR_W (ADDR_W)
   ) entries_i (
      .clk                      (clk),
      .rst_n                    (rst_n),
      .store_valid_dc3          (store_valid_dc3),
      .wr_waddr                 (wr_waddr),
      .wr_byteen                (wr_byteen),
      .wr_data                  (wr_data),
      .lsu_commit_dc5           (lsu_commit_dc5),
      .isldst_dc1               (isldst_dc1),
      .isldst_dc2               (isldst_dc2),
      .isldst_dc3               (isldst_dc3),
      .lsu_stbuf_commit_any     (lsu_stbuf_commit_any),
      .entry_state              (entry_state),
      .entry_waddr              (entry_waddr),
      .entry_byteen             (entry_byteen),
      .entry_data               (entry_data),
      .wr_ptr                   (wr_ptr),
      .stbuf_reqvld_any         (stbuf_reqvld_any),
      .stbuf_reqvld_flushed_any (stbuf_reqvld_flushed_any),
      .stbuf_addr_any           (stbuf_addr_any),
      .stbuf_byteen_any         (stbuf_byteen_any),
      .stbuf_data_any           (stbuf_data_any),
      .lsu_stbuf_full_any       (lsu_stbuf_full_any),
      .lsu_stbuf_empty_any      (lsu_stbuf_empty_any)
   );

   // load forwarding, result in dc3
   stbuf_fwd #(
      .DEPTH  (DEPTH),
      .ADDR_W (ADDR_W)
   ) fwd_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .lsu_cmpen_dc2       (lsu_cmpen_dc2),
      .lsu_addr_dc2        (lsu_addr_dc2),
      .load_size_dc2       (load_size_dc2),
      .entry_state         (entry_state),
      .entry_waddr         (entry_waddr),
      .entry_byteen        (entry_byteen),
      .entry_data          (entry_data),
      .wr_ptr              (wr_ptr),
      .stbuf_fwddata_dc3   (stbuf_fwddata_dc3),
      .stbuf_fwdbyteen_dc3 (stbuf_fwdbyteen_dc3)
   );

endmodule

`default_nettype wire

//--- logic/stbuf_entries.sv
`timescale 1ns/1ns
`default_nettype none

module stbuf_entries
   import stbuf_pkg::*;
#(
   parameter int DEPTH  = STBUF_DEPTH,
   parameter int ADDR_W = STBUF_ADDR_W
) (
   input  logic                           clk,
   input  logic                           rst_n,

   // store write from dc3
   input  logic                           store_valid_dc3,
   input  logic [ADDR_W-3:0]              wr_waddr,
   input  logic [BYTE_W-1:0]              wr_byteen,
   input  logic [DATA_W-1:0]              wr_data,

   input  logic                           lsu_commit_dc5,   // resolves the dc5 store
   input  logic                           isldst_dc1,
   input  logic                           isldst_dc2,
   input  logic                           isldst_dc3,
   input  logic                           lsu_stbuf_commit_any,   // memory side pop

   // entry view for forwarding
   output entry_state_e [DEPTH-1:0]       entry_state,
   output logic [DEPTH-1:0][ADDR_W-3:0]   entry_waddr,
   output logic [DEPTH-1:0][BYTE_W-1:0]   entry_byteen,
   output logic [DEPTH-1:0][DATA_W-1:0]   entry_data,
   output logic [$clog2(DEPTH)-1:0]       wr_ptr,

   // drain head
   output logic                           stbuf_reqvld_any,
   output logic                           stbuf_reqvld_flushed_any,
   output logic [ADDR_W-1:0]              stbuf_addr_any,
   output logic [BYTE_W-1:0]              stbuf_byteen_any,
   output logic [DATA_W-1:0]              stbuf_data_any,

   output logic                           lsu_stbuf_full_any,
   output logic                           lsu_stbuf_empty_any
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = PTR_W + 2;   // live entries plus three in flight

   logic [PTR_W-1:0]  rd_ptr;
   logic              valid_dc4, valid_dc5;
   logic [PTR_W-1:0]  ptr_dc4, ptr_dc5;
   logic              pop;
   logic [DEPTH-1:0]  wr_en;
   logic [DEPTH-1:0]  resolve_en;
   logic [DEPTH-1:0]  pop_en;
   logic [CNT_W-1:0]  num_vld;
   logic [CNT_W-1:0]  spec_vld;

   if (DEPTH < 4 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
      $error("stbuf_entries: DEPTH must be a power of two of at least 4");
   end

   assign pop = lsu_stbuf_commit_any | stbuf_reqvld_flushed_any;

   for (genvar i = 0; i < DEPTH; i++) begin : g_entry_en
      assign wr_en[i]      = store_valid_dc3 & (wr_ptr == PTR_W'(i));
      assign resolve_en[i] = valid_dc5 & (ptr_dc5 == PTR_W'(i));
      assign pop_en[i]     = pop & (rd_ptr == PTR_W'(i));
   end

   // ------------------------------
   // entry state
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            entry_state[i] <= ENTRY_FREE;
         end
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (wr_en[i]) begin
               entry_state[i] <= ENTRY_PENDING;
            end else if (resolve_en[i]) begin
               if (lsu_commit_dc5) begin
                  entry_state[i] <= ENTRY_DRAIN;
               end else begin
                  entry_state[i] <= ENTRY_FLUSHED;
               end
            end else if (pop_en[i]) begin
               entry_state[i] <= ENTRY_FREE;
            end
         end
      end
   end

   // payload, already lane aligned by the decoder
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_en[i]) begin
            entry_waddr[i]  <= wr_waddr;
            entry_byteen[i] <= wr_byteen;
            entry_data[i]   <= wr_data;
         end
      end
   end

   // ------------------------------
   // pointers and dc4/dc5 staging
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         valid_dc4 <= 1'b0;
         valid_dc5 <= 1'b0;
         ptr_dc4   <= '0;
         ptr_dc5   <= '0;
      end else begin
         if (store_valid_dc3) wr_ptr <= wr_ptr + 1'b1;
         if (pop)             rd_ptr <= rd_ptr + 1'b1;
         valid_dc4 <= store_valid_dc3;
         valid_dc5 <= valid_dc4;
         ptr_dc4   <= wr_ptr;   // slot taken by the dc3 store
         ptr_dc5   <= ptr_dc4;
      end
   end

   // ------------------------------
   // drain head
   // ------------------------------
   assign stbuf_reqvld_any         = (entry_state[rd_ptr] == ENTRY_DRAIN);
   assign stbuf_reqvld_flushed_any = (entry_state[rd_ptr] == ENTRY_FLUSHED);   // freed at next edge
   assign stbuf_addr_any           = {entry_waddr[rd_ptr], 2'b00};   // word aligned byte address
   assign stbuf_byteen_any         = entry_byteen[rd_ptr];
   assign stbuf_data_any           = entry_data[rd_ptr];

   // full and empty
   always_comb begin
      num_vld = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (entry_state[i] != ENTRY_FREE) num_vld = num_vld + 1'b1;
      end
   end

   assign spec_vld = num_vld + CNT_W'(isldst_dc1) + CNT_W'(isldst_dc2) + CNT_W'(isldst_dc3);

   assign lsu_stbuf_full_any  = (spec_vld > CNT_W'(DEPTH - 2));
   assign lsu_stbuf_empty_any = (num_vld == '0);

   // ------------------------------
   // checks
   // ------------------------------
   // the full flag must have kept the pipeline from overrunning the head
   a_write_free: assert property (@(posedge clk) disable iff (!rst_n)
      store_valid_dc3 |-> entry_state[wr_ptr] == ENTRY_FREE)
      else $error("store written into a live entry");

   a_pop_reqvld: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_stbuf_commit_any |-> stbuf_reqvld_any)
      else $error("pop strobe without a committed head");

   // the slot written two cycles earlier is still waiting
   a_resolve_pending: assert property (@(posedge clk) disable iff (!rst_n)
      valid_dc5 |-> entry_state[ptr_dc5] == ENTRY_PENDING)
      else $error("dc5 resolution on an entry that is not pending");

endmodule

`default_nettype wire

//--- logic/stbuf_fwd.sv
`timescale 1ns/1ns
`default_nettype none

module stbuf_fwd
   import stbuf_pkg::*;
#(
   parameter int DEPTH  = STBUF_DEPTH,
   parameter int ADDR_W = STBUF_ADDR_W
) (
   input  logic                           clk,
   input  logic                           rst_n,

   // load compare in dc2
   input  logic                           lsu_cmpen_dc2,
   input  logic [ADDR_W-1:0]              lsu_addr_dc2,
   input  access_size_e                   load_size_dc2,

   input  entry_state_e [DEPTH-1:0]       entry_state,
   input  logic [DEPTH-1:0][ADDR_W-3:0]   entry_waddr,
   input  logic [DEPTH-1:0][BYTE_W-1:0]   entry_byteen,
   input  logic [DEPTH-1:0][DATA_W-1:0]   entry_data,
   input  logic [$clog2(DEPTH)-1:0]       wr_ptr,

   output logic [DATA_W-1:0]              stbuf_fwddata_dc3,
   output logic [BYTE_W-1:0]              stbuf_fwdbyteen_dc3
);

   localparam int PTR_W = $clog2(DEPTH);

   logic [BYTE_W-1:0]             load_mask;
   logic [DEPTH-1:0]              ldmatch;
   logic [BYTE_W-1:0]             lane_hit;   // some live entry covers the lane
   logic [BYTE_W-1:0][PTR_W-1:0]  win_idx;    // youngest entry per lane
   logic [BYTE_W-1:0]             fwd_en_dc2;
   logic [DATA_W-1:0]             fwd_data_dc2;

   assign load_mask = size_mask(load_size_dc2) << lsu_addr_dc2[1:0];

   // ------------------------------
   // address match
   // ------------------------------
   for (genvar i = 0; i < DEPTH; i++) begin : g_match
      assign ldmatch[i] = ((entry_state[i] == ENTRY_PENDING) |
                           (entry_state[i] == ENTRY_DRAIN)) &
                          (entry_waddr[i] == lsu_addr_dc2[ADDR_W-1:2]);
   end

   // oldest slot sits at wr_ptr, so later hits are younger and override
   always_comb begin
      logic [PTR_W-1:0] idx;
      lane_hit = '0;
      win_idx  = '0;
      for (int j = 0; j < DEPTH; j++) begin
         idx = wr_ptr + PTR_W'(j);
         for (int b = 0; b < BYTE_W; b++) begin
            if (ldmatch[idx] && entry_byteen[idx][b]) begin
               lane_hit[b] = 1'b1;
               win_idx[b]  = idx;
            end
         end
      end
   end

   // ------------------------------
   // byte merge
   // ------------------------------
   assign fwd_en_dc2 = lane_hit & load_mask & {BYTE_W{lsu_cmpen_dc2}};

   for (genvar b = 0; b < BYTE_W; b++) begin : g_lane
      assign fwd_data_dc2[8*b +: 8] = fwd_en_dc2[b] ? entry_data[win_idx[b]][8*b +: 8] : 8'h00;
   end

   // dc3 register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stbuf_fwdbyteen_dc3 <= '0;
         stbuf_fwddata_dc3   <= '0;
      end else begin
         stbuf_fwdbyteen_dc3 <= fwd_en_dc2;
         stbuf_fwddata_dc3   <= fwd_data_dc2;
      end
   end

   // a dc3 lane must trace back to an entry that was live at the compare
   for (genvar b = 0; b < BYTE_W; b++) begin : g_chk
      a_fwd_live: assert property (@(posedge clk) disable iff (!rst_n)
         stbuf_fwdbyteen_dc3[b] |->
            $past(entry_state[win_idx[b]] == ENTRY_PENDING ||
                  entry_state[win_idx[b]] == ENTRY_DRAIN))
         else $error("lane %0d forwarded from a free or flushed entry", b);
   end

endmodule

`default_nettype wire

//--- logic/stbuf_pkg.sv
`default_nettype none

package stbuf_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   parameter int STBUF_DEPTH  = 4;    // entries, power of two, at least 4
   parameter int STBUF_ADDR_W = 16;   // byte address width
   parameter int DATA_W       = 32;   // one bank
   parameter int BYTE_W       = 4;    // byte lanes per bank

   // access size of a store or a load
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00,
      SIZE_HALF = 2'b01,
      SIZE_WORD = 2'b10
   } access_size_e;

   // life cycle of one buffer entry
   typedef enum logic [1:0] {
      ENTRY_FREE    = 2'b00,   // holds nothing
      ENTRY_PENDING = 2'b01,   // written in dc3, waiting for dc5
      ENTRY_DRAIN   = 2'b10,   // committed, goes to memory
      ENTRY_FLUSHED = 2'b11    // killed, dropped at the head
   } entry_state_e;

   // byte mask of an access at offset 0
   function automatic logic [BYTE_W-1:0] size_mask(access_size_e size);
      logic [BYTE_W-1:0] mask;
      case (size)
         SIZE_BYTE: mask = 4'b0001;
         SIZE_HALF: mask = 4'b0011;
         SIZE_WORD: mask = 4'b1111;
         default:   mask = 4'b0000;
      endcase
      return mask;
   endfunction

endpackage

`default_nettype wire

//--- logic/stbuf_write_decode.sv
`timescale 1ns/1ns
`default_nettype none

module stbuf_write_decode
   import stbuf_pkg::*;
#(
   parameter int ADDR_W = STBUF_ADDR_W
) (
   input  access_size_e        store_size_dc3,
   input  logic [ADDR_W-1:0]   store_addr_dc3,
   input  logic [DATA_W-1:0]   store_data_dc3,
   output logic [ADDR_W-3:0]   wr_waddr,
   output logic [BYTE_W-1:0]   wr_byteen,
   output logic [DATA_W-1:0]   wr_data
);

   logic [1:0]        byte_off;   // offset inside the bank
   logic [BYTE_W-1:0] base_mask;

   assign byte_off  = store_addr_dc3[1:0];
   assign base_mask = size_mask(store_size_dc3);

   // ------------------------------
   // lane alignment
   // ------------------------------
   // the access must stay inside the word, so nothing is shifted out
   assign wr_waddr  = store_addr_dc3[ADDR_W-1:2];
   assign wr_byteen = base_mask << byte_off;

   always_comb begin
      case (byte_off)
         2'd0:    wr_data = store_data_dc3;
         2'd1:    wr_data = {store_data_dc3[23:0], 8'h00};
         2'd2:    wr_data = {store_data_dc3[15:0], 16'h0000};
         default: wr_data = {store_data_dc3[7:0], 24'h000000};   // byte in lane 3
      endcase
   end

endmodule

`default_nettype wire

//--- lsu_stbuf.f
+incdir+tests
logic/stbuf_pkg.sv
logic/stbuf_write_decode.sv
logic/stbuf_entries.sv
logic/stbuf_fwd.sv
logic/lsu_stbuf.sv
tests/tb_lsu_stbuf.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the store buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_stbuf \
   -f lsu_stbuf.f -o tb_lsu_stbuf > build.log 2>&1 &&
   ./obj_dir/tb_lsu_stbuf > sim.log 2>&1 ||
   echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q -F '*** TEST PASSED ***' sim.log && echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }

//--- tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------
// error counters
// ------------------------------
int flag_errors  = 0;
int drain_errors = 0;
int fwd_errors   = 0;
int other_errors = 0;   // timeouts and stuck drains

// one-bit status flags
task automatic flag_check(string name, logic got, logic exp);
   if (got !== exp) begin
      flag_errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
   end
endtask

// drain head, compared only while a committed entry is at the head
task automatic drain_check(logic [ADDR_W-1:0] got_addr, logic [BYTE_W-1:0] got_en,
                           logic [DATA_W-1:0] got_data, logic [ADDR_W-1:0] exp_addr,
                           logic [BYTE_W-1:0] exp_en, logic [DATA_W-1:0] exp_data);
   if (got_addr !== exp_addr) begin
      drain_errors++;
      $display("[FAIL] %0t stbuf_addr_any got %h expected %h", $time, got_addr, exp_addr);
   end
   if (got_en !== exp_en) begin
      drain_errors++;
      $display("[FAIL] %0t stbuf_byteen_any got %b expected %b", $time, got_en, exp_en);
   end
   if (got_data !== exp_data) begin
      drain_errors++;
      $display("[FAIL] %0t stbuf_data_any got %h expected %h", $time, got_data, exp_data);
   end
endtask

// forwarded lanes in dc3
task automatic fwd_check(logic [BYTE_W-1:0] got_en, logic [DATA_W-1:0] got_data,
                         logic [BYTE_W-1:0] exp_en, logic [DATA_W-1:0] exp_data);
   if (got_en !== exp_en) begin
      fwd_errors++;
      $display("[FAIL] %0t stbuf_fwdbyteen_dc3 got %b expected %b", $time, got_en, exp_en);
   end
   if (got_data !== exp_data) begin
      fwd_errors++;
      $display("[FAIL] %0t stbuf_fwddata_dc3 got %h expected %h", $time, got_data, exp_data);
   end
endtask

function automatic int error_total();
   return flag_errors + drain_errors + fwd_errors + other_errors;
endfunction

task automatic report_counts();
   $display("errors: %0d flag, %0d drain, %0d forward, %0d other, %0d total",
            flag_errors, drain_errors, fwd_errors, other_errors, error_total());
endtask

`endif

//--- tests/tb_lsu_stbuf.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_stbuf
   import stbuf_pkg::*;
();

   localparam int DEPTH     = STBUF_DEPTH;
   localparam int ADDR_W    = STBUF_ADDR_W;
   localparam int NUM_TESTS = 6;
   localparam int SLOTS     = 64;   // model slots reused round robin

   logic               clk, rst_n;
   logic               store_valid_dc3;
   access_size_e       store_size_dc3;
   logic [ADDR_W-1:0]  store_addr_dc3;
   logic [DATA_W-1:0]  store_data_dc3;
   logic               lsu_commit_dc5, isldst_dc1, isldst_dc2, isldst_dc3;
   logic               lsu_stbuf_commit_any, lsu_cmpen_dc2;
   logic [ADDR_W-1:0]  lsu_addr_dc2;
   access_size_e       load_size_dc2;
   logic               stbuf_reqvld_any, stbuf_reqvld_flushed_any;
   logic [ADDR_W-1:0]  stbuf_addr_any;
   logic [BYTE_W-1:0]  stbuf_byteen_any, stbuf_fwdbyteen_dc3;
   logic [DATA_W-1:0]  stbuf_data_any, stbuf_fwddata_dc3;
   logic               lsu_stbuf_full_any, lsu_stbuf_empty_any;

   // ------------------------------
   // reference model
   // ------------------------------
   int unsigned        live_q[$];   // live slots oldest first
   entry_state_e       m_state [SLOTS];
   logic [ADDR_W-1:0]  m_addr  [SLOTS];   // word aligned
   logic [BYTE_W-1:0]  m_en    [SLOTS];
   logic [DATA_W-1:0]  m_data  [SLOTS];
   bit                 m_commit[SLOTS];
   int unsigned        next_slot, slot_dc4, slot_dc5;
   bit                 vld_dc4, vld_dc5, pend_commit;
   logic [BYTE_W-1:0]  exp_fwd_en;
   logic [DATA_W-1:0]  exp_fwd_data;
   int                 seed;

   `include "tb_checks.svh"

   lsu_stbuf #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      #(NUM_TESTS * 200 * 4);
      $display("watchdog expired before the tests finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

   function automatic logic [BYTE_W-1:0] lane_mask(access_size_e size, logic [1:0] off);
      int nbytes;
      nbytes = 1 << int'(size);   // 1, 2 or 4 bytes
      return BYTE_W'((1 << nbytes) - 1) << off;
   endfunction

   function automatic logic [ADDR_W-1:0] aligned_addr(access_size_e size, logic [31:0] r);
      logic [1:0] off;
      case (size)
         SIZE_BYTE: off = r[1:0];
         SIZE_HALF: off = {r[1], 1'b0};
         default:   off = 2'b00;
      endcase
      return ADDR_W'(32'h0400 + 32'(r[3:2]) * 4 + 32'(off));   // four words only
   endfunction

   task automatic outputs_check();
      int unsigned h;
      bit          hv;
      int          inflight;
      hv       = live_q.size() > 0;
      h        = hv ? live_q[0] : 0;
      inflight = int'(isldst_dc1) + int'(isldst_dc2) + int'(isldst_dc3);
      flag_check("lsu_stbuf_empty_any", lsu_stbuf_empty_any, !hv);
      flag_check("lsu_stbuf_full_any", lsu_stbuf_full_any,
                 (live_q.size() + inflight) > DEPTH - 2);
      flag_check("stbuf_reqvld_any", stbuf_reqvld_any, hv && m_state[h] == ENTRY_DRAIN);
      flag_check("stbuf_reqvld_flushed_any", stbuf_reqvld_flushed_any,
                 hv && m_state[h] == ENTRY_FLUSHED);
      if (hv && m_state[h] == ENTRY_DRAIN) begin
         drain_check(stbuf_addr_any, stbuf_byteen_any, stbuf_data_any,
                     m_addr[h], m_en[h], m_data[h]);
      end
      fwd_check(stbuf_fwdbyteen_dc3, stbuf_fwddata_dc3, exp_fwd_en, exp_fwd_data);
   endtask

   // one clock edge of the model from this cycle's inputs
   task automatic model_edge();
      int unsigned       s;
      logic [BYTE_W-1:0] lmask;
      exp_fwd_en   = '0;
      exp_fwd_data = '0;
      if (lsu_cmpen_dc2) begin
         lmask = lane_mask(load_size_dc2, lsu_addr_dc2[1:0]);
         foreach (live_q[k]) begin   // younger entries override
            s = live_q[k];
            if (m_state[s] inside {ENTRY_PENDING, ENTRY_DRAIN} &&
                m_addr[s][ADDR_W-1:2] == lsu_addr_dc2[ADDR_W-1:2]) begin
               for (int b = 0; b < BYTE_W; b++) begin
                  if (m_en[s][b] && lmask[b]) begin
                     exp_fwd_en[b]          = 1'b1;
                     exp_fwd_data[8*b +: 8] = m_data[s][8*b +: 8];
                  end
               end
            end
         end
      end
      if (live_q.size() > 0) begin
         s = live_q[0];
         if (m_state[s] == ENTRY_FLUSHED || (m_state[s] == ENTRY_DRAIN && lsu_stbuf_commit_any))
            void'(live_q.pop_front());
      end
      if (vld_dc5) m_state[slot_dc5] = lsu_commit_dc5 ? ENTRY_DRAIN : ENTRY_FLUSHED;
      vld_dc5  = vld_dc4;
      slot_dc5 = slot_dc4;
      vld_dc4  = store_valid_dc3;
      if (store_valid_dc3) begin
         s           = next_slot % SLOTS;
         m_state[s]  = ENTRY_PENDING;
         m_addr[s]   = {store_addr_dc3[ADDR_W-1:2], 2'b00};
         m_en[s]     = lane_mask(store_size_dc3, store_addr_dc3[1:0]);
         m_data[s]   = store_data_dc3 << (8 * int'(store_addr_dc3[1:0]));
         m_commit[s] = pend_commit;
         live_q.push_back(s);
         slot_dc4    = s;
         next_slot++;
      end
   endtask

   task automatic tick();
      if (vld_dc5) lsu_commit_dc5 = m_commit[slot_dc5];
      else         lsu_commit_dc5 = 1'($random(seed));   // ignored with no store in dc5
      #1;
      outputs_check();
      @(posedge clk);
      model_edge();
      @(negedge clk);
      store_valid_dc3      = 1'b0;
      lsu_stbuf_commit_any = 1'b0;
      lsu_cmpen_dc2        = 1'b0;
   endtask

   task automatic issue_store(access_size_e size, logic [ADDR_W-1:0] addr,
                              logic [DATA_W-1:0] data, bit commit);
      store_valid_dc3 = 1'b1;
      store_size_dc3  = size;
      store_addr_dc3  = addr;
      store_data_dc3  = data;
      pend_commit     = commit;
   endtask

   task automatic issue_load(access_size_e size, logic [ADDR_W-1:0] addr);
      lsu_cmpen_dc2 = 1'b1;
      load_size_dc2 = size;
      lsu_addr_dc2  = addr;
   endtask

   task automatic pop_when_ready();
      int waited;
      waited = 0;
      while (!stbuf_reqvld_any && waited < 8) begin
         tick();
         waited++;
      end
      if (stbuf_reqvld_any) begin
         lsu_stbuf_commit_any = 1'b1;
      end else begin
         other_errors++;
         $display("no committed store reached the drain head within 8 cycles at %0t", $time);
      end
      tick();
   endtask

   task automatic drain_remaining();
      int n;
      n = 0;
      while (live_q.size() != 0 && n < 40) begin
         if (m_state[live_q[0]] == ENTRY_DRAIN) lsu_stbuf_commit_any = 1'b1;
         tick();
         n++;
      end
      if (live_q.size() != 0) begin
         other_errors++;
         $display("store buffer did not drain within 40 cycles at %0t", $time);
      end
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic reset_state_test();
      tick();
      tick();
   endtask

   task automatic commit_drain_test();
      issue_store(SIZE_WORD, 16'h0100, 32'h11223344, 1'b1);
      tick();
      issue_store(SIZE_HALF, 16'h0106, 32'h0000aabb, 1'b1);
      tick();
      issue_store(SIZE_BYTE, 16'h010b, 32'h000000cc, 1'b1);
      tick();
      drain_check(stbuf_addr_any, stbuf_byteen_any, stbuf_data_any,
                  16'h0100, 4'b1111, 32'h11223344);
      repeat (3) pop_when_ready();
      flag_check("lsu_stbuf_empty_any", lsu_stbuf_empty_any, 1'b1);
   endtask

   task automatic flush_test();
      issue_store(SIZE_WORD, 16'h0500, 32'h01010101, 1'b0);
      tick();
      issue_store(SIZE_HALF, 16'h0504, 32'h00002222, 1'b1);
      tick();
      issue_store(SIZE_BYTE, 16'h0509, 32'h00000033, 1'b0);
      tick();
      tick();   // flushed head drops out
      issue_store(SIZE_WORD, 16'h050c, 32'h44444444, 1'b1);
      tick();
      repeat (2) pop_when_ready();
      tick();
   endtask

   task automatic forward_merge_test();
      issue_store(SIZE_WORD, 16'h0200, 32'ha1a2a3a4, 1'b1);
      tick();
      issue_store(SIZE_BYTE, 16'h0201, 32'h000000b5, 1'b1);
      tick();
      issue_store(SIZE_HALF, 16'h0202, 32'h0000c6c7, 1'b1);
      tick();
      issue_load(SIZE_WORD, 16'h0200);
      tick();
      fwd_check(stbuf_fwdbyteen_dc3, stbuf_fwddata_dc3, 4'b1111, 32'hc6c7b5a4);
      issue_load(SIZE_HALF, 16'h0202);
      tick();
      issue_load(SIZE_BYTE, 16'h0201);
      tick();
      issue_load(SIZE_WORD, 16'h0300);   // other word
      tick();
      repeat (2) pop_when_ready();   // halfword store stays live
      issue_store(SIZE_WORD, 16'h0200, 32'hdeadbeef, 1'b0);
      repeat (3) tick();
      issue_load(SIZE_WORD, 16'h0200);   // younger flushed word must not win
      tick();
      fwd_check(stbuf_fwdbyteen_dc3, stbuf_fwddata_dc3, 4'b1100, 32'hc6c70000);
      drain_remaining();
      tick();
   endtask

   task automatic full_flag_test();
      for (int n = 0; n < 3; n++) begin
         {isldst_dc1, isldst_dc2, isldst_dc3} = 3'b000;
         issue_store(SIZE_WORD, ADDR_W'(16'h0300 + 4 * n), 32'h5a5a0000 + n, 1'b1);
         tick();
         for (int c = 0; c < 8; c++) begin
            {isldst_dc1, isldst_dc2, isldst_dc3} = 3'(c);
            tick();
         end
      end
      {isldst_dc1, isldst_dc2, isldst_dc3} = 3'b000;
      drain_remaining();
      tick();
   endtask

   task automatic random_mix_test();
      logic [31:0]  r;
      access_size_e size;
      int           inflight;
      for (int i = 0; i < 250; i++) begin
         r = $random(seed);
         {isldst_dc1, isldst_dc2, isldst_dc3} = r[2:0];
         inflight = int'(r[0]) + int'(r[1]) + int'(r[2]);
         if (r[5] && (live_q.size() + inflight) <= DEPTH - 2) begin
            size = (r[10:9] == 2'b11) ? SIZE_WORD : access_size_e'(r[10:9]);
            issue_store(size, aligned_addr(size, $random(seed)), $random(seed), r[6]);
         end
         if (r[7]) begin
            size = (r[12:11] == 2'b11) ? SIZE_HALF : access_size_e'(r[12:11]);
            issue_load(size, aligned_addr(size, $random(seed)));
         end
         if (r[8] && live_q.size() > 0 && m_state[live_q[0]] == ENTRY_DRAIN)
            lsu_stbuf_commit_any = 1'b1;
         tick();
      end
      {isldst_dc1, isldst_dc2, isldst_dc3} = 3'b000;
      drain_remaining();
      tick();
   endtask

   initial begin
      seed                 = 32'hb03e;
      rst_n                = 1'b0;
      store_valid_dc3      = 1'b0;
      store_size_dc3       = SIZE_BYTE;
      store_addr_dc3       = '0;
      store_data_dc3       = '0;
      lsu_commit_dc5       = 1'b0;
      {isldst_dc1, isldst_dc2, isldst_dc3} = 3'b000;
      lsu_stbuf_commit_any = 1'b0;
      lsu_cmpen_dc2        = 1'b0;
      lsu_addr_dc2         = '0;
      load_size_dc2        = SIZE_BYTE;
      next_slot            = 0;
      {vld_dc4, vld_dc5, pend_commit} = 3'b000;
      {slot_dc4, slot_dc5} = '0;
      exp_fwd_en           = '0;
      exp_fwd_data         = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      reset_state_test();
      commit_drain_test();
      flush_test();
      forward_merge_test();
      full_flag_test();
      random_mix_test();
      report_counts();
      if (error_total() == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
